// File: verilog.f
src/dcache_pkg.sv
src/dcache_data_ram.sv
src/dcache_lru.sv
src/dcache_tag_store.sv
src/dcache_ctrl.sv
src/dcache.sv
sim/dcache_properties.sv
sim/dcache_checker.sv
sim/tb_dcache.sv

// File: Makefile
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= TEST FAILED

.PHONY: sim clean

# an aborted run (for example a failed assertion) is logged as a failure
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int    num_sets     = 4;
    localparam int    num_ways     = 4;
    localparam int    mem_words    = 4096;
    localparam word_t fill_pattern = 64'h9e37_79b9_7f4a_7c15;
    localparam int    wait_limit   = 200;
    localparam int    num_rows     = 20;
    // a line in set 1, never cached before the mid-test reset
    localparam addr_t burst_addr   = 32'h0000_0080;

    typedef struct packed {
        logic    rst;
        addr_t   addr;
        logic    write;
        strobe_t strobe;
        word_t   data;
        logic    exp_hit;
        logic    exp_wb;
        addr_t   wb_addr;
    } row_t;

    logic        clk = 1'b0;
    logic        reset;
    cpu_req_t    cpu_req;
    cpu_resp_t   cpu_resp;
    mem_req_t    mem_req;
    mem_resp_t   mem_resp = '0;
    logic        expect_hit;
    logic        expect_wb;
    addr_t       expect_wb_addr;
    int unsigned data_errors;
    int unsigned flow_errors;
    int unsigned timeout_errors;

    word_t mem [mem_words];
    row_t  rows [num_rows];

    always #10 clk = ~clk;

    dcache #(
        .num_sets(num_sets),
        .num_ways(num_ways)
    ) i_dcache (
        .clk      (clk),
        .reset    (reset),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    dcache_checker #(
        .mem_words   (mem_words),
        .fill_pattern(fill_pattern)
    ) i_checker (
        .clk            (clk),
        .reset          (reset),
        .cpu_req        (cpu_req),
        .cpu_resp       (cpu_resp),
        .mem_req        (mem_req),
        .mem_resp       (mem_resp),
        .expect_hit     (expect_hit),
        .expect_wb      (expect_wb),
        .expect_wb_addr (expect_wb_addr),
        .data_errors    (data_errors),
        .flow_errors    (flow_errors)
    );

    function automatic int word_index(addr_t a);
        return int'((a >> byte_bits) % mem_words);
    endfunction

    // burst memory, one beat per cycle while mem_req.valid is high
    initial begin
        mem_resp_t resp;
        int        idx;
        int        mem_beat;
        mem_beat = 0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = word_t'(i) ^ fill_pattern;
        end
        forever begin
            @(posedge clk);
            #2;
            resp = '0;
            if (mem_req.valid === 1'b1) begin
                idx = word_index(mem_req.addr) + mem_beat;
                if (mem_req.is_write) begin
                    mem[idx] = mem_req.data;
                end else begin
                    resp.data = mem[idx];
                end
                resp.ready = 1'b1;
                resp.last  = (mem_beat == words_per_line - 1);
                mem_beat   = resp.last ? 0 : mem_beat + 1;
            end else begin
                mem_beat = 0;
            end
            mem_resp = resp;
        end
    end

    // set 0 lines sit 0x200 apart, expected hits follow the lru ages by hand
    task automatic load_table();
        // rst, addr, write, strobe, data, exp_hit, exp_wb, wb_addr
        rows[0]  = '{1'b0, 32'h0000_0000, 1'b0, 8'h00, 64'h0, 1'b0, 1'b0, 32'h0};
        rows[1]  = '{1'b0, 32'h0000_0018, 1'b0, 8'h00, 64'h0, 1'b1, 1'b0, 32'h0};
        rows[2]  = '{1'b0, 32'h0000_0020, 1'b1, 8'h0f, 64'h1122_3344_5566_7788, 1'b1, 1'b0, 32'h0};
        rows[3]  = '{1'b0, 32'h0000_0020, 1'b0, 8'h00, 64'h0, 1'b1, 1'b0, 32'h0};
        rows[4]  = '{1'b0, 32'h0000_0200, 1'b0, 8'h00, 64'h0, 1'b0, 1'b0, 32'h0};
        rows[5]  = '{1'b0, 32'h0000_0400, 1'b0, 8'h00, 64'h0, 1'b0, 1'b0, 32'h0};
        rows[6]  = '{1'b0, 32'h0000_0600, 1'b0, 8'h00, 64'h0, 1'b0, 1'b0, 32'h0};
        // re-touch of the first line
        rows[7]  = '{1'b0, 32'h0000_0008, 1'b0, 8'h00, 64'h0, 1'b1, 1'b0, 32'h0};
        rows[8]  = '{1'b0, 32'h0000_0800, 1'b0, 8'h00, 64'h0, 1'b0, 1'b0, 32'h0};
        rows[9]  = '{1'b0, 32'h0000_0200, 1'b0, 8'h00, 64'h0, 1'b0, 1'b0, 32'h0};
        rows[10] = '{1'b0, 32'h0000_0010, 1'b0, 8'h00, 64'h0, 1'b1, 1'b0, 32'h0};
        rows[11] = '{1'b0, 32'h0000_0600, 1'b0, 8'h00, 64'h0, 1'b1, 1'b0, 32'h0};
        rows[12] = '{1'b0, 32'h0000_0808, 1'b0, 8'h00, 64'h0, 1'b1, 1'b0, 32'h0};
        rows[13] = '{1'b0, 32'h0000_0210, 1'b0, 8'h00, 64'h0, 1'b1, 1'b0, 32'h0};
        // dirty line 0x0000 is now oldest
        rows[14] = '{1'b0, 32'h0000_0a00, 1'b0, 8'h00, 64'h0, 1'b0, 1'b1, 32'h0000_0000};
        rows[15] = '{1'b0, 32'h0000_0020, 1'b0, 8'h00, 64'h0, 1'b0, 1'b0, 32'h0};
        rows[16] = '{1'b1, 32'h0000_0010, 1'b0, 8'h00, 64'h0, 1'b0, 1'b0, 32'h0};
        rows[17] = '{1'b0, 32'h0000_0018, 1'b0, 8'h00, 64'h0, 1'b1, 1'b0, 32'h0};
        rows[18] = '{1'b0, 32'h0000_0208, 1'b1, 8'hf0, 64'hcafe_f00d_dead_beef, 1'b0, 1'b0, 32'h0};
        rows[19] = '{1'b0, 32'h0000_0208, 1'b0, 8'h00, 64'h0, 1'b1, 1'b0, 32'h0};
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
    endtask

    // start a refill and reset the cache while its burst is running
    task automatic reset_in_burst();
        bit seen;
        int cycles;
        cpu_req.valid  = 1'b1;
        cpu_req.addr   = burst_addr;
        cpu_req.strobe = '0;
        cpu_req.data   = '0;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < wait_limit) begin
            @(negedge clk);
            seen = mem_req.valid;
            cycles++;
        end
        if (!seen) begin
            timeout_errors++;
            $display("no memory burst within %0d cycles for the request at %h",
                     wait_limit, burst_addr);
        end
        @(posedge clk);
        #2;
        apply_reset();
        cpu_req = '0;
    endtask

    // hold the request until data_ok, then drop it after that edge
    task automatic run_request(input row_t r, output bit ok);
        int cycles;
        cpu_req.valid  = 1'b1;
        cpu_req.addr   = r.addr;
        cpu_req.strobe = r.write ? r.strobe : '0;
        cpu_req.data   = r.data;
        expect_hit     = r.exp_hit;
        expect_wb      = r.exp_wb;
        expect_wb_addr = r.wb_addr;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < wait_limit) begin
            @(negedge clk);
            ok = cpu_resp.data_ok;
            cycles++;
        end
        if (!ok) begin
            timeout_errors++;
            $display("no data_ok within %0d cycles for the request at %h", wait_limit, r.addr);
        end
        @(posedge clk);
        #2;
        cpu_req = '0;
    endtask

    initial begin
        bit          ok;
        int unsigned total;
        cpu_req        = '0;
        expect_hit     = 1'b0;
        expect_wb      = 1'b0;
        expect_wb_addr = '0;
        timeout_errors = 0;
        load_table();
        apply_reset();
        for (int i = 0; i < num_rows; i++) begin
            if (rows[i].rst) begin
                reset_in_burst();
            end
            run_request(rows[i], ok);
            if (!ok) begin
                break;
            end
        end
        total = data_errors + flow_errors + timeout_errors;
        $display("errors: data %0d, flow %0d, timeout %0d",
                 data_errors, flow_errors, timeout_errors);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/dcache_checker.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_checker #(
    parameter int                mem_words    = 4096,
    parameter dcache_pkg::word_t fill_pattern = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  dcache_pkg::cpu_req_t  cpu_req,
    input  dcache_pkg::cpu_resp_t cpu_resp,
    input  dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_resp_t mem_resp,
    input  logic                  expect_hit,
    input  logic                  expect_wb,
    input  dcache_pkg::addr_t     expect_wb_addr,
    output int unsigned           data_errors,
    output int unsigned           flow_errors
);
    import dcache_pkg::*;

    localparam addr_t line_mask = addr_t'((words_per_line << byte_bits) - 1);

    // what the cpu should see for every word
    word_t shadow [mem_words];

    function automatic int word_index(addr_t a);
        return int'((a >> byte_bits) % mem_words);
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wdata, strobe_t strobe);
        word_t result;
        result = old;
        for (int b = 0; b < $bits(strobe_t); b++) begin
            if (strobe[b]) begin
                result[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return result;
    endfunction

    // sampled at the falling edge, all inputs and outputs are settled there
    initial begin
        word_t expected;
        addr_t bus_addr;
        int    idx;
        int    wait_cycles;
        int    wb_beat;
        logic  saw_bus;
        logic  saw_wb;
        logic  reset_prev;
        data_errors = 0;
        flow_errors = 0;
        wait_cycles = 0;
        wb_beat     = 0;
        saw_bus     = 1'b0;
        saw_wb      = 1'b0;
        reset_prev  = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = word_t'(i) ^ fill_pattern;
        end
        forever begin
            @(negedge clk);
            if (reset_prev) begin
                if (cpu_resp.data_ok !== 1'b0) begin
                    flow_errors++;
                    $display("Fail cpu_resp.data_ok after reset: got %h, expected 0",
                             cpu_resp.data_ok);
                end
                if (mem_req.valid !== 1'b0) begin
                    flow_errors++;
                    $display("Fail mem_req.valid after reset: got %h, expected 0",
                             mem_req.valid);
                end
                wait_cycles = 0;
                wb_beat     = 0;
                saw_bus     = 1'b0;
                saw_wb      = 1'b0;
            end else begin
                if (mem_req.valid) begin
                    saw_bus  = 1'b1;
                    // evicted line on write-back, requested line on refill
                    bus_addr = mem_req.is_write ? expect_wb_addr : (cpu_req.addr & ~line_mask);
                    if (mem_req.addr !== bus_addr) begin
                        flow_errors++;
                        $display("Fail mem_req.addr: got %h, expected %h",
                                 mem_req.addr, bus_addr);
                    end
                    if (mem_req.is_write) begin
                        saw_wb = 1'b1;
                        if (mem_resp.ready) begin
                            expected = shadow[word_index(bus_addr) + wb_beat];
                            if (mem_req.data !== expected) begin
                                data_errors++;
                                $display("Fail mem_req.data: beat %0d got %h, expected %h",
                                         wb_beat, mem_req.data, expected);
                            end
                            wb_beat = mem_resp.last ? 0 : wb_beat + 1;
                        end
                    end
                end
                if (cpu_req.valid && cpu_resp.data_ok) begin
                    idx = word_index(cpu_req.addr);
                    if (|cpu_req.strobe) begin
                        shadow[idx] = merge_bytes(shadow[idx], cpu_req.data, cpu_req.strobe);
                    end else if (cpu_resp.data !== shadow[idx]) begin
                        data_errors++;
                        $display("Fail cpu_resp.data: addr %h got %h, expected %h",
                                 cpu_req.addr, cpu_resp.data, shadow[idx]);
                    end
                    if (saw_bus == expect_hit) begin
                        flow_errors++;
                        $display("request at %h: expected %s, but the cache did otherwise",
                                 cpu_req.addr, expect_hit ? "a hit" : "a miss");
                    end
                    if (saw_wb != expect_wb) begin
                        flow_errors++;
                        $display("request at %h: write-back burst %s",
                                 cpu_req.addr, expect_wb ? "missing" : "not expected");
                    end
                    if (expect_hit && wait_cycles != 1) begin
                        flow_errors++;
                        $display("hit at %h answered after %0d cycles instead of 1",
                                 cpu_req.addr, wait_cycles);
                    end
                    wait_cycles = 0;
                    saw_bus     = 1'b0;
                    saw_wb      = 1'b0;
                end else if (cpu_req.valid) begin
                    wait_cycles++;
                end
            end
            reset_prev = reset;
        end
    end

endmodule

`default_nettype wire

// File: sim/dcache_properties.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_properties (
    input logic                  clk,
    input logic                  reset,
    input dcache_pkg::cpu_req_t  cpu_req,
    input dcache_pkg::cpu_resp_t cpu_resp,
    input dcache_pkg::mem_req_t  mem_req,
    input dcache_pkg::mem_resp_t mem_resp
);

    // a response only answers a pending request
    data_ok_needs_request: assert property (
        @(posedge clk) disable iff (reset)
        cpu_resp.data_ok |-> cpu_req.valid
    ) else $error("data_ok without a pending cpu request");

    // address and direction hold until the last beat
    burst_stable: assert property (
        @(posedge clk) disable iff (reset)
        (mem_req.valid && !mem_resp.last) |=>
            (mem_req.valid && $stable(mem_req.addr) && $stable(mem_req.is_write))
    ) else $error("memory burst changed before its last beat");

    reset_quiet: assert property (
        @(posedge clk)
        reset |=> (!mem_req.valid && !cpu_resp.data_ok)
    ) else $error("bus request or data_ok active right after reset");

endmodule

bind dcache_ctrl dcache_properties i_properties (
    .clk      (clk),
    .reset    (reset),
    .cpu_req  (cpu_req),
    .cpu_resp (cpu_resp),
    .mem_req  (mem_req),
    .mem_resp (mem_resp)
);

`default_nettype wire

// File: src/dcache.sv
`timescale 1ns/100ps
`default_nettype none

module dcache #(
    parameter int num_sets = 4,
    parameter int num_ways = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output dcache_pkg::cpu_resp_t cpu_resp,
    output dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_resp_t mem_resp
);
    import dcache_pkg::*;

    localparam int index_bits    = $clog2(num_sets);
    localparam int way_bits      = $clog2(num_ways);
    localparam int tag_bits      = $bits(addr_t) - index_bits - offset_bits - byte_bits;
    localparam int ram_addr_bits = index_bits + way_bits + offset_bits;

    // lookup results from the tag store
    logic                hit;
    logic [way_bits-1:0] hit_way;
    logic [way_bits-1:0] victim_way;
    logic                victim_valid;
    logic                victim_dirty;
    logic [tag_bits-1:0] victim_tag;
    logic [num_ways-1:0] set_valid;
    logic [way_bits-1:0] lru_way;

    // metadata write command
    logic                meta_we;
    logic [way_bits-1:0] meta_way;
    logic                meta_dirty;
    logic [tag_bits-1:0] meta_tag;
    logic                touch;

    // data ram port
    logic                     ram_en;
    logic [ram_addr_bits-1:0] ram_addr;
    strobe_t                  ram_strobe;
    word_t                    ram_wdata;
    word_t                    ram_rdata;

    dcache_ctrl #(
        .num_sets(num_sets),
        .num_ways(num_ways)
    ) i_ctrl (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .cpu_resp     (cpu_resp),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .ram_rdata    (ram_rdata),
        .meta_we      (meta_we),
        .meta_way     (meta_way),
        .meta_dirty   (meta_dirty),
        .meta_tag     (meta_tag),
        .touch        (touch),
        .ram_en       (ram_en),
        .ram_addr     (ram_addr),
        .ram_strobe   (ram_strobe),
        .ram_wdata    (ram_wdata)
    );

    dcache_tag_store #(
        .num_sets(num_sets),
        .num_ways(num_ways)
    ) i_tag_store (
        .clk          (clk),
        .reset        (reset),
        .addr         (cpu_req.addr),
        .meta_we      (meta_we),
        .meta_way     (meta_way),
        .meta_dirty   (meta_dirty),
        .meta_tag     (meta_tag),
        .lru_way      (lru_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .set_valid    (set_valid)
    );

    dcache_lru #(
        .num_sets(num_sets),
        .num_ways(num_ways)
    ) i_lru (
        .clk       (clk),
        .reset     (reset),
        .addr      (cpu_req.addr),
        .touch     (touch),
        .hit_way   (hit_way),
        .set_valid (set_valid),
        .lru_way   (lru_way)
    );

    dcache_data_ram #(
        .num_sets(num_sets),
        .num_ways(num_ways)
    ) i_data_ram (
        .clk    (clk),
        .en     (ram_en),
        .addr   (ram_addr),
        .strobe (ram_strobe),
        .wdata  (ram_wdata),
        .rdata  (ram_rdata)
    );

endmodule

`default_nettype wire

// File: src/dcache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl #(
    parameter int num_sets = 4,
    parameter int num_ways = 4,
    localparam int index_bits = $clog2(num_sets),
    localparam int way_bits   = $clog2(num_ways),
    localparam int tag_bits   = $bits(dcache_pkg::addr_t) - index_bits
                                - dcache_pkg::offset_bits - dcache_pkg::byte_bits,
    localparam int ram_addr_bits = index_bits + way_bits + dcache_pkg::offset_bits
) (
    input  logic                     clk,
    input  logic                     reset,
    input  dcache_pkg::cpu_req_t     cpu_req,
    output dcache_pkg::cpu_resp_t    cpu_resp,
    output dcache_pkg::mem_req_t     mem_req,
    input  dcache_pkg::mem_resp_t    mem_resp,
    input  logic                     hit,
    input  logic [way_bits-1:0]      hit_way,
    input  logic [way_bits-1:0]      victim_way,
    input  logic                     victim_valid,
    input  logic                     victim_dirty,
    input  logic [tag_bits-1:0]      victim_tag,
    input  dcache_pkg::word_t        ram_rdata,
    output logic                     meta_we,
    output logic [way_bits-1:0]      meta_way,
    output logic                     meta_dirty,
    output logic [tag_bits-1:0]      meta_tag,
    output logic                     touch,
    output logic                     ram_en,
    output logic [ram_addr_bits-1:0] ram_addr,
    output dcache_pkg::strobe_t      ram_strobe,
    output dcache_pkg::word_t        ram_wdata
);
    import dcache_pkg::*;

    cache_state_e           state;
    cache_state_e           state_next;
    logic [offset_bits-1:0] beat;

    // fields of the request address
    logic [tag_bits-1:0]    req_tag;
    logic [index_bits-1:0]  req_index;
    logic [offset_bits-1:0] req_offset;
    logic                   req_write;

    logic [way_bits-1:0]    line_way;
    logic [offset_bits-1:0] line_word;
    logic [tag_bits-1:0]    bus_tag;
    logic                   in_burst;

    assign req_tag    = cpu_req.addr[$bits(addr_t)-1 -: tag_bits];
    assign req_index  = cpu_req.addr[byte_bits + offset_bits +: index_bits];
    assign req_offset = cpu_req.addr[byte_bits +: offset_bits];
    assign req_write  = |cpu_req.strobe;
    assign in_burst   = (state == ALLOCATE) || (state == WRITEBACK);

    // during refill the new tag is already written, so the line shows up as a hit
    assign line_way  = hit ? hit_way : victim_way;
    assign line_word = (state == COMPARE) ? req_offset : beat;
    assign ram_addr  = {req_index, line_way, line_word};

    // write-back goes to the old line, refill to the requested one
    assign bus_tag = (state == WRITEBACK) ? victim_tag : req_tag;

    always_comb begin
        mem_req.valid    = in_burst;
        mem_req.is_write = (state == WRITEBACK);
        mem_req.addr     = {bus_tag, req_index, {(offset_bits + byte_bits){1'b0}}};
        mem_req.data     = ram_rdata;
    end

    always_comb begin
        cpu_resp.data_ok = (state == COMPARE) && hit;
        cpu_resp.data    = ram_rdata;
    end

    // ram writes: the strobed bytes of a write hit, or one refill beat
    always_comb begin
        ram_en     = 1'b0;
        ram_strobe = cpu_req.strobe;
        ram_wdata  = cpu_req.data;
        case (state)
            COMPARE: begin
                ram_en = hit && req_write;
            end
            ALLOCATE: begin
                ram_en     = mem_resp.ready;
                ram_strobe = '1;
                ram_wdata  = mem_resp.data;
            end
            default: begin
                ram_en = 1'b0;
            end
        endcase
    end

    assign meta_tag = req_tag;

    always_comb begin
        state_next = state;
        meta_we    = 1'b0;
        meta_way   = victim_way;
        meta_dirty = 1'b0;
        touch      = 1'b0;
        case (state)
            IDLE: begin
                if (cpu_req.valid) begin
                    state_next = COMPARE;
                end
            end
            COMPARE: begin
                if (hit) begin
                    touch      = 1'b1;
                    state_next = IDLE;
                    // write hit marks the line dirty
                    if (req_write) begin
                        meta_we    = 1'b1;
                        meta_way   = hit_way;
                        meta_dirty = 1'b1;
                    end
                end else if (victim_valid && victim_dirty) begin
                    state_next = WRITEBACK;
                end else begin
                    meta_we    = 1'b1;
                    state_next = ALLOCATE;
                end
            end
            WRITEBACK: begin
                if (mem_resp.last) begin
                    meta_we    = 1'b1;
                    state_next = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (mem_resp.last) begin
                    state_next = COMPARE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // beat counter, word offset within the burst
    always_ff @(posedge clk) begin
        if (reset || !in_burst || mem_resp.last) begin
            beat <= '0;
        end else if (mem_resp.ready) begin
            beat <= beat + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tag_store #(
    parameter int num_sets = 4,
    parameter int num_ways = 4,
    localparam int index_bits = $clog2(num_sets),
    localparam int way_bits   = $clog2(num_ways),
    localparam int tag_bits   = $bits(dcache_pkg::addr_t) - index_bits
                                - dcache_pkg::offset_bits - dcache_pkg::byte_bits
) (
    input  logic                clk,
    input  logic                reset,
    input  dcache_pkg::addr_t   addr,
    input  logic                meta_we,
    input  logic [way_bits-1:0] meta_way,
    input  logic                meta_dirty,
    input  logic [tag_bits-1:0] meta_tag,
    input  logic [way_bits-1:0] lru_way,
    output logic                hit,
    output logic [way_bits-1:0] hit_way,
    output logic [way_bits-1:0] victim_way,
    output logic                victim_valid,
    output logic                victim_dirty,
    output logic [tag_bits-1:0] victim_tag,
    output logic [num_ways-1:0] set_valid
);
    import dcache_pkg::*;

    logic [num_ways-1:0] valid_q [num_sets];
    logic [num_ways-1:0] dirty_q [num_sets];
    logic [tag_bits-1:0] tag_q [num_sets][num_ways];

    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   addr_tag;
    logic                  has_free;
    logic [way_bits-1:0]   free_way;

    assign index     = addr[byte_bits + offset_bits +: index_bits];
    assign addr_tag  = addr[$bits(addr_t)-1 -: tag_bits];
    assign set_valid = valid_q[index];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (meta_we) begin
            valid_q[index][meta_way] <= 1'b1;
            dirty_q[index][meta_way] <= meta_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (meta_we) begin
            tag_q[index][meta_way] <= meta_tag;
        end
    end

    // parallel compare across the ways of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (valid_q[index][w] && (tag_q[index][w] == addr_tag)) begin
                hit     = 1'b1;
                hit_way = way_bits'(w);
            end
        end
    end

    // lowest invalid way wins over the lru choice
    always_comb begin
        has_free = 1'b0;
        free_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_q[index][w]) begin
                has_free = 1'b1;
                free_way = way_bits'(w);
            end
        end
    end

    assign victim_way   = has_free ? free_way : lru_way;
    assign victim_valid = valid_q[index][victim_way];
    assign victim_dirty = dirty_q[index][victim_way];
    assign victim_tag   = tag_q[index][victim_way];

endmodule

`default_nettype wire

// File: src/dcache_lru.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_lru #(
    parameter int num_sets = 4,
    parameter int num_ways = 4,
    localparam int index_bits = $clog2(num_sets),
    localparam int way_bits   = $clog2(num_ways)
) (
    input  logic                clk,
    input  logic                reset,
    input  dcache_pkg::addr_t   addr,
    input  logic                touch,
    input  logic [way_bits-1:0] hit_way,
    input  logic [num_ways-1:0] set_valid,
    output logic [way_bits-1:0] lru_way
);
    import dcache_pkg::*;

    // age 0 is the most recently used way
    logic [way_bits-1:0] age_q [num_sets][num_ways];

    logic [index_bits-1:0] index;
    logic [way_bits-1:0]   touched_age;
    logic [way_bits-1:0]   oldest_age;

    assign index       = addr[byte_bits + offset_bits +: index_bits];
    assign touched_age = age_q[index][hit_way];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    age_q[s][w] <= '1;
                end
            end
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (!set_valid[w]) begin
                    // empty ways stay oldest
                    age_q[index][w] <= '1;
                end else if (touch) begin
                    if (way_bits'(w) == hit_way) begin
                        age_q[index][w] <= '0;
                    end else if (age_q[index][w] < touched_age) begin
                        age_q[index][w] <= age_q[index][w] + 1'b1;
                    end
                end
            end
        end
    end

    // strict compare keeps the lowest index on a tie
    always_comb begin
        lru_way    = '0;
        oldest_age = age_q[index][0];
        for (int w = 1; w < num_ways; w++) begin
            if (age_q[index][w] > oldest_age) begin
                oldest_age = age_q[index][w];
                lru_way    = way_bits'(w);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_data_ram #(
    parameter int num_sets = 4,
    parameter int num_ways = 4,
    localparam int addr_bits = $clog2(num_sets) + $clog2(num_ways) + dcache_pkg::offset_bits,
    localparam int depth     = num_sets * num_ways * dcache_pkg::words_per_line
) (
    input  logic                 clk,
    input  logic                 en,
    input  logic [addr_bits-1:0] addr,
    input  dcache_pkg::strobe_t  strobe,
    input  dcache_pkg::word_t    wdata,
    output dcache_pkg::word_t    rdata
);
    import dcache_pkg::*;

    // word address is {set, way, word offset}
    word_t mem_q [depth];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < $bits(strobe_t); b++) begin
                if (strobe[b]) begin
                    mem_q[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // combinational read, feeds both cpu data and write-back beats
    assign rdata = mem_q[addr];

endmodule

`default_nettype wire

// File: src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // one bus word and its byte lanes
    typedef logic [63:0] word_t;
    typedef logic [7:0]  strobe_t;
    typedef logic [31:0] addr_t;

    // line geometry, shared by the cache and the memory bus
    localparam int words_per_line = 16;
    localparam int offset_bits    = $clog2(words_per_line);
    localparam int byte_bits      = $clog2($bits(word_t) / 8);

    // cpu side, strobe of zero is a read
    typedef struct packed {
        logic    valid;
        addr_t   addr;
        strobe_t strobe;
        word_t   data;
    } cpu_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t data;
    } cpu_resp_t;

    // memory side, always 16-beat incrementing bursts of whole words
    typedef struct packed {
        logic  valid;
        logic  is_write;
        addr_t addr;
        word_t data;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } mem_resp_t;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        ALLOCATE,
        WRITEBACK
    } cache_state_e;

endpackage

`default_nettype wire
